// ==== source/led_matrix_pkg.sv ====
// ******************************************************************
// led matrix package: opcodes, colour and config structs and the
// command word with its two-way payload decode
// ******************************************************************
package led_matrix_pkg;

    localparam int COLOR_BITS = 4;          // bits per channel, also plane count

    localparam logic [7:0] OP_PIXEL  = 8'h50;
    localparam logic [7:0] OP_CONFIG = 8'h43;

    // one pixel, red in the top nibble
    typedef struct packed {
        logic [COLOR_BITS-1:0] red;
        logic [COLOR_BITS-1:0] green;
        logic [COLOR_BITS-1:0] blue;
    } color_t;

    typedef struct packed {
        logic [2:0]            rgb_enable;    // red is bit 2
        logic [COLOR_BITS-1:0] plane_enable;  // bit n gates plane n
    } config_t;

    typedef struct packed {
        logic [3:0] pad;
        color_t     color;
    } pixel_view_t;

    typedef struct packed {
        logic [8:0] pad;
        config_t    cfg;
    } config_view_t;

    // same 16 payload bits, read per opcode
    typedef union packed {
        pixel_view_t  pixel;
        config_view_t conf;
    } payload_u;

    typedef struct packed {
        logic [7:0] opcode;
        logic [7:0] addr;
        payload_u   payload;
    } cmd_t;

    typedef struct packed {
        logic       half;   // 1 = bottom half
        logic [1:0] row;    // row pair inside the half
        logic [2:0] col;
        color_t     color;
    } pix_write_t;

endpackage

// ==== source/cmd_decode.sv ====
// ******************************************************************
// command decoder: packs strobed bytes into 4-byte commands and
// passes on pixel and config commands only
// ******************************************************************
module cmd_decode
    import led_matrix_pkg::*;
(
    input  logic       clk_root,
    input  logic       rst_n,
    input  logic       byte_valid,
    input  logic [7:0] byte_data,
    output cmd_t       cmd,
    output logic       cmd_valid
);

    logic [1:0]  byte_cnt;   // position inside the command
    logic [23:0] head;       // opcode, addr, payload high
    cmd_t        next_cmd;
    logic        known_op;
    logic        last_byte;

    // word as it would be with the current byte as the 4th
    assign next_cmd  = cmd_t'({head, byte_data});
    assign known_op  = (next_cmd.opcode == OP_PIXEL) || (next_cmd.opcode == OP_CONFIG);
    assign last_byte = byte_valid && (byte_cnt == 2'd3);

    // control path
    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            byte_cnt  <= 2'd0;
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= last_byte && known_op;  // unknown opcodes die here
            if (byte_valid) begin
                byte_cnt <= byte_cnt + 2'd1;     // wraps after 4 bytes
            end
        end
    end

    // data path
    always_ff @(posedge clk_root) begin
        if (byte_valid) begin
            if (byte_cnt == 2'd3) begin
                cmd <= next_cmd;
            end else begin
                head <= {head[15:0], byte_data};
            end
        end
    end

endmodule

// ==== source/frame_store.sv ====
// ******************************************************************
// frame store: top and bottom pixel memories and the config
// register, written by decoded commands, read by the scan
// ******************************************************************
module frame_store
    import led_matrix_pkg::*;
#(
    parameter int COLS      = 8,
    parameter int ROW_PAIRS = 4
) (
    input  logic                                clk_root,
    input  logic                                rst_n,
    input  cmd_t                                cmd,
    input  logic                                cmd_valid,
    input  logic [$clog2(ROW_PAIRS*COLS)-1:0]   rd_index,
    output color_t                              pix_top,
    output color_t                              pix_bottom,
    output config_t                             cfg
);

    localparam int CW    = $clog2(COLS);
    localparam int RW    = $clog2(ROW_PAIRS);
    localparam int DEPTH = COLS * ROW_PAIRS;

    color_t mem_top    [DEPTH];
    color_t mem_bottom [DEPTH];

    pix_write_t          wr;
    logic [RW+CW-1:0]    wr_index;

    // addr is {half, row pair, col} from the msb down
    always_comb begin
        wr.half  = cmd.addr[CW+RW];
        wr.row   = 2'(cmd.addr[CW+RW-1:CW]);
        wr.col   = 3'(cmd.addr[CW-1:0]);
        wr.color = cmd.payload.pixel.color;
    end

    assign wr_index = {RW'(wr.row), CW'(wr.col)};

    always_ff @(posedge clk_root) begin
        if (cmd_valid && (cmd.opcode == OP_PIXEL)) begin
            if (wr.half) begin
                mem_bottom[wr_index] <= wr.color;
            end else begin
                mem_top[wr_index] <= wr.color;
            end
        end
        pix_top    <= mem_top[rd_index];     // one cycle read
        pix_bottom <= mem_bottom[rd_index];
    end

    // everything enabled out of reset
    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            cfg <= config_t'('1);
        end else if (cmd_valid && (cmd.opcode == OP_CONFIG)) begin
            cfg <= cmd.payload.conf.cfg;
        end
    end

endmodule

// ==== source/matrix_scan.sv ====
// ******************************************************************
// matrix scan: shift, latch and display sequence per row pair and
// bit-plane, with pixel fetch and channel and plane masking
// ******************************************************************
module matrix_scan
    import led_matrix_pkg::*;
#(
    parameter int COLS      = 8,
    parameter int ROW_PAIRS = 4,
    parameter int OE_UNIT   = 4
) (
    input  logic                                clk_root,
    input  logic                                rst_n,
    input  color_t                              pix_top,
    input  color_t                              pix_bottom,
    input  config_t                             cfg,
    output logic [$clog2(ROW_PAIRS*COLS)-1:0]   rd_index,
    output logic [2:0]                          rgb_top,
    output logic [2:0]                          rgb_bottom,
    output logic [$clog2(ROW_PAIRS)-1:0]        row_addr,
    output logic                                clk_pixel,
    output logic                                row_latch,
    output logic                                output_enable
);

    localparam int RW = $clog2(ROW_PAIRS);
    localparam int TW = $clog2(2 * COLS);       // two cycles per column
    localparam int PW = $clog2(COLOR_BITS);
    localparam int DW = $clog2(OE_UNIT * (1 << (COLOR_BITS - 1)) + 1);

    typedef enum logic [1:0] {
        SHIFT,
        LATCH,
        SHOW
    } phase_t;

    phase_t        phase;
    logic [TW-1:0] tick;
    logic [DW-1:0] dcnt;       // display cycles left
    logic [PW-1:0] plane;
    logic [RW-1:0] row_pair;
    logic          issue;
    logic          strobe_d1;
    logic          latch_d1;
    logic          oe_d1;

    // pick this plane's bit of each channel, then apply both enables
    function automatic logic [2:0] plane_bits(color_t px, logic [PW-1:0] pl, config_t c);
        logic [2:0] bits;
        bits = {px.red[pl], px.green[pl], px.blue[pl]};
        return bits & c.rgb_enable & {3{c.plane_enable[pl]}};
    endfunction

    // read address on even shift ticks, column is tick / 2
    assign issue    = (phase == SHIFT) && !tick[0];
    assign rd_index = {row_pair, tick[TW-1:1]};

    // sequencer, runs two cycles ahead of the panel pins
    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            phase    <= SHIFT;
            tick     <= '0;
            dcnt     <= '0;
            plane    <= '0;
            row_pair <= '0;
        end else begin
            case (phase)
                SHIFT: begin
                    if (tick == TW'(2 * COLS - 1)) begin
                        tick  <= '0;
                        phase <= LATCH;
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                LATCH: begin
                    dcnt  <= DW'(OE_UNIT) << plane;  // binary weighted on time
                    phase <= SHOW;
                end
                default: begin
                    if (dcnt == DW'(1)) begin
                        phase <= SHIFT;
                        plane <= plane + 1'b1;
                        if (plane == PW'(COLOR_BITS - 1)) begin
                            row_pair <= row_pair + 1'b1;  // planes inside row pair
                        end
                    end else begin
                        dcnt <= dcnt - 1'b1;
                    end
                end
            endcase
        end
    end

    // two stage delay lines, matching the memory read latency
    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            strobe_d1     <= 1'b0;
            latch_d1      <= 1'b0;
            oe_d1         <= 1'b0;
            clk_pixel     <= 1'b0;
            row_latch     <= 1'b0;
            output_enable <= 1'b0;
            row_addr      <= '0;
        end else begin
            strobe_d1     <= issue;
            latch_d1      <= (phase == LATCH);
            oe_d1         <= (phase == SHOW);
            clk_pixel     <= strobe_d1;
            row_latch     <= latch_d1;
            output_enable <= oe_d1;
            if (latch_d1) begin
                row_addr <= row_pair;  // held through the display time
            end
        end
    end

    // pixel data is valid while strobe_d1 is high
    always_ff @(posedge clk_root) begin
        if (strobe_d1) begin
            rgb_top    <= plane_bits(pix_top, plane, cfg);
            rgb_bottom <= plane_bits(pix_bottom, plane, cfg);
        end
    end

endmodule

// ==== source/led_matrix_top.sv ====
// ******************************************************************
// led matrix top: byte command decode, frame store and panel scan
// ******************************************************************
module led_matrix_top
    import led_matrix_pkg::*;
#(
    parameter int COLS      = 8,
    parameter int ROW_PAIRS = 4,
    parameter int OE_UNIT   = 4
) (
    input  logic                            clk_root,
    input  logic                            rst_n,
    input  logic                            byte_valid,
    input  logic [7:0]                      byte_data,
    output logic [2:0]                      rgb_top,
    output logic [2:0]                      rgb_bottom,
    output logic [$clog2(ROW_PAIRS)-1:0]    row_addr,
    output logic                            clk_pixel,
    output logic                            row_latch,
    output logic                            output_enable
);

    cmd_t                                cmd;
    logic                                cmd_valid;
    logic [$clog2(ROW_PAIRS*COLS)-1:0]   rd_index;   // {row pair, col}
    color_t                              pix_top;
    color_t                              pix_bottom;
    config_t                             cfg;

    cmd_decode u_decode (
        .clk_root   (clk_root),
        .rst_n      (rst_n),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid)
    );

    frame_store #(
        .COLS       (COLS),
        .ROW_PAIRS  (ROW_PAIRS)
    ) u_store (
        .clk_root   (clk_root),
        .rst_n      (rst_n),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .rd_index   (rd_index),
        .pix_top    (pix_top),
        .pix_bottom (pix_bottom),
        .cfg        (cfg)
    );

    matrix_scan #(
        .COLS          (COLS),
        .ROW_PAIRS     (ROW_PAIRS),
        .OE_UNIT       (OE_UNIT)
    ) u_scan (
        .clk_root      (clk_root),
        .rst_n         (rst_n),
        .pix_top       (pix_top),
        .pix_bottom    (pix_bottom),
        .cfg           (cfg),
        .rd_index      (rd_index),
        .rgb_top       (rgb_top),
        .rgb_bottom    (rgb_bottom),
        .row_addr      (row_addr),
        .clk_pixel     (clk_pixel),
        .row_latch     (row_latch),
        .output_enable (output_enable)
    );

endmodule

// ==== bench/scan_checker.sv ====
// ******************************************************************
// scan checker: shadow framebuffer and config rebuilt from the byte
// stream, compared with the panel pins and the scan timing
// ******************************************************************
module scan_checker #(
    parameter int COLS      = 8,
    parameter int ROW_PAIRS = 4,
    parameter int OE_UNIT   = 4
) (
    input  logic                          clk_root,
    input  logic                          rst_n,
    input  logic                          check_en,
    input  logic                          byte_valid,
    input  logic [7:0]                    byte_data,
    input  logic [2:0]                    rgb_top,
    input  logic [2:0]                    rgb_bottom,
    input  logic [$clog2(ROW_PAIRS)-1:0]  row_addr,
    input  logic                          clk_pixel,
    input  logic                          row_latch,
    input  logic                          output_enable,
    output int                            pixel_errs,
    output int                            timing_errs,
    output int                            pixel_checks
);

    localparam int PLANES = 4;
    localparam int RW     = $clog2(ROW_PAIRS);

    logic [11:0]   shadow  [2*ROW_PAIRS][COLS];  // red, green, blue nibbles
    bit            written [2*ROW_PAIRS][COLS];
    logic [2:0]    rgb_en;
    logic [3:0]    plane_en;
    logic [23:0]   head;
    int            byte_pos;
    int            step;           // row-plane steps latched since reset
    int            col;            // strobes since the last latch
    int            oe_len;
    int            latched_plane;
    logic [RW-1:0] latched_row;
    logic          oe_prev;
    logic          rst_prev = 1'b1;
    int            n_pix_err = 0;
    int            n_time_err = 0;
    int            n_checks = 0;

    assign pixel_errs   = n_pix_err;
    assign timing_errs  = n_time_err;
    assign pixel_checks = n_checks;

    function automatic logic [2:0] expected_bits(logic [11:0] px, int pl);
        logic [2:0] raw;
        raw = {px[8 + pl], px[4 + pl], px[pl]};
        return raw & rgb_en & {3{plane_en[pl]}};
    endfunction

    // address is row * COLS + col, rows past ROW_PAIRS are the bottom half
    task automatic apply_command(input logic [31:0] c);
        int row;
        int cc;
        row = (int'(c[23:16]) / COLS) % (2 * ROW_PAIRS);
        cc  = int'(c[23:16]) % COLS;
        if (c[31:24] == 8'h50) begin
            shadow[row][cc]  = c[11:0];
            written[row][cc] = 1'b1;
        end else if (c[31:24] == 8'h43) begin
            rgb_en   = c[6:4];
            plane_en = c[3:0];
        end
    endtask

    task automatic compare_half(input string name, input int row, input logic [2:0] got);
        logic [2:0] exp;
        if (written[row][col]) begin
            exp = expected_bits(shadow[row][col], step % PLANES);
            n_checks++;
            if (got !== exp) begin
                n_pix_err++;
                $display("MISMATCH t=%0t %s row %0d col %0d plane %0d got %b expected %b",
                         $time, name, row, col, step % PLANES, got, exp);
            end
        end
    endtask

    always @(posedge clk_root) begin
        if (!rst_prev && (clk_pixel || row_latch || output_enable || row_addr != '0)) begin
            n_time_err++;
            $display("MISMATCH t=%0t panel controls not idle around reset", $time);
        end
        rst_prev = rst_n;
        if (!rst_n) begin
            byte_pos      = 0;
            rgb_en        = '1;
            plane_en      = '1;
            step          = 0;
            col           = 0;
            oe_len        = 0;
            oe_prev       = 1'b0;
            latched_plane = 0;
            latched_row   = '0;
        end else begin
            if (byte_valid) begin
                if (byte_pos == 3) begin
                    apply_command({head, byte_data});
                end else begin
                    head = {head[15:0], byte_data};
                end
                byte_pos = (byte_pos + 1) % 4;
            end
            if (clk_pixel) begin
                if (check_en && col < COLS) begin
                    compare_half("top", (step / PLANES) % ROW_PAIRS, rgb_top);
                    compare_half("bottom", (step / PLANES) % ROW_PAIRS + ROW_PAIRS, rgb_bottom);
                end
                col++;
            end
            if (row_latch) begin
                if (col != COLS) begin
                    n_time_err++;
                    $display("MISMATCH t=%0t %0d pixel strobes before row latch, expected %0d",
                             $time, col, COLS);
                end
                col           = 0;
                oe_len        = 0;
                latched_plane = step % PLANES;
                latched_row   = RW'((step / PLANES) % ROW_PAIRS);
                step          = (step + 1) % (PLANES * ROW_PAIRS);
            end
            if (output_enable) begin
                oe_len++;
                if (row_addr != latched_row) begin
                    n_time_err++;
                    $display("MISMATCH t=%0t row_addr %0d while showing row pair %0d",
                             $time, row_addr, latched_row);
                end
            end else if (oe_prev && oe_len != (OE_UNIT << latched_plane)) begin
                n_time_err++;
                $display("MISMATCH t=%0t output_enable high %0d cycles, expected %0d",
                         $time, oe_len, OE_UNIT << latched_plane);
            end
            oe_prev = output_enable;
        end
    end

endmodule

// ==== bench/led_matrix_sva.sv ====
// ******************************************************************
// scan control assertions, bound into matrix_scan
// ******************************************************************
module led_matrix_sva (
    input logic clk_root,
    input logic rst_n,
    input logic clk_pixel,
    input logic row_latch,
    input logic output_enable
);

    int fail_count = 0;   // failed assertions so far

    // shift, latch and display never overlap
    pulses_exclusive: assert property (@(posedge clk_root) disable iff (!rst_n)
        $onehot0({clk_pixel, row_latch, output_enable}))
        else begin
            $error("clk_pixel, row_latch and output_enable high together");
            fail_count = fail_count + 1;
        end

    // one latch cycle, display starts right behind it
    latch_single: assert property (@(posedge clk_root) disable iff (!rst_n)
        row_latch |=> !row_latch && output_enable)
        else begin
            $error("row_latch not a single cycle followed by output_enable");
            fail_count = fail_count + 1;
        end

endmodule

bind matrix_scan led_matrix_sva u_sva (
    .clk_root      (clk_root),
    .rst_n         (rst_n),
    .clk_pixel     (clk_pixel),
    .row_latch     (row_latch),
    .output_enable (output_enable)
);

// ==== bench/tb_top.sv ====
// ******************************************************************
// led matrix testbench: byte stream from the vector file with random
// gaps, scan checker, watchdog and closing report
// ******************************************************************
module tb_top;

    localparam int COLS         = 8;
    localparam int ROW_PAIRS    = 4;
    localparam int OE_UNIT      = 4;
    localparam int RESET_CYCLES = 5;
    localparam int MAX_CMDS     = 32;

    logic                         clk_root;
    logic                         rst_n;
    logic                         byte_valid;
    logic [7:0]                   byte_data;
    logic                         check_en;
    logic [2:0]                   rgb_top;
    logic [2:0]                   rgb_bottom;
    logic [$clog2(ROW_PAIRS)-1:0] row_addr;
    logic                         clk_pixel;
    logic                         row_latch;
    logic                         output_enable;
    logic [31:0]                  vectors [MAX_CMDS];   // all ones marks unused
    int                           n_cmds = 0;
    int                           pixel_errs;
    int                           timing_errs;
    int                           pixel_checks;
    int                           sva_errs;
    int                           gap;
    integer                       seed;

    // shift 2 per column, one latch cycle, weighted display time
    function automatic int frame_cycles();
        int total;
        int p;
        total = 0;
        for (p = 0; p < 4; p++) begin
            total += 2 * COLS + 1 + (OE_UNIT << p);
        end
        return total * ROW_PAIRS;
    endfunction

    task automatic send_command(input logic [31:0] word);
        int b;
        for (b = 0; b < 4; b++) begin
            @(negedge clk_root);
            byte_valid = 1'b1;
            byte_data  = word[8*(3-b) +: 8];   // opcode first
            gap        = int'($unsigned($random(seed)) % 4);
            repeat (gap) begin
                @(negedge clk_root);
                byte_valid = 1'b0;
            end
        end
    endtask

    led_matrix_top #(
        .COLS          (COLS),
        .ROW_PAIRS     (ROW_PAIRS),
        .OE_UNIT       (OE_UNIT)
    ) DUT (
        .clk_root      (clk_root),
        .rst_n         (rst_n),
        .byte_valid    (byte_valid),
        .byte_data     (byte_data),
        .rgb_top       (rgb_top),
        .rgb_bottom    (rgb_bottom),
        .row_addr      (row_addr),
        .clk_pixel     (clk_pixel),
        .row_latch     (row_latch),
        .output_enable (output_enable)
    );

    scan_checker #(
        .COLS          (COLS),
        .ROW_PAIRS     (ROW_PAIRS),
        .OE_UNIT       (OE_UNIT)
    ) u_checker (
        .clk_root      (clk_root),
        .rst_n         (rst_n),
        .check_en      (check_en),
        .byte_valid    (byte_valid),
        .byte_data     (byte_data),
        .rgb_top       (rgb_top),
        .rgb_bottom    (rgb_bottom),
        .row_addr      (row_addr),
        .clk_pixel     (clk_pixel),
        .row_latch     (row_latch),
        .output_enable (output_enable),
        .pixel_errs    (pixel_errs),
        .timing_errs   (timing_errs),
        .pixel_checks  (pixel_checks)
    );

    assign sva_errs = DUT.u_scan.u_sva.fail_count;

    initial begin
        clk_root = 1'b0;
        forever #5 clk_root = ~clk_root;
    end

    initial begin
        rst_n      = 1'b0;
        byte_valid = 1'b0;
        byte_data  = 8'h00;
        check_en   = 1'b0;
        seed       = 10;
        foreach (vectors[i]) vectors[i] = '1;
        $readmemh("bench/cmd_vectors.txt", vectors);
        while (n_cmds < MAX_CMDS && vectors[n_cmds] != '1) n_cmds++;
        repeat (RESET_CYCLES) @(posedge clk_root);
        @(negedge clk_root);
        rst_n = 1'b1;
        for (int i = 0; i < n_cmds; i++) begin
            send_command(vectors[i]);
        end
        @(negedge clk_root);
        byte_valid = 1'b0;
        repeat (frame_cycles()) @(negedge clk_root);   // let the last command settle
        check_en = 1'b1;
        repeat (2 * frame_cycles()) @(negedge clk_root);
        check_en = 1'b0;
        @(posedge clk_root);
        $display("errors: pixel %0d, timing %0d, assertion %0d (pixel compares %0d)",
                 pixel_errs, timing_errs, sva_errs, pixel_checks);
        if (pixel_checks == 0) begin
            $display("no pixel strobes were compared");
        end
        if (pixel_errs + timing_errs + sva_errs == 0 && pixel_checks > 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // worst case is 4 cycles per byte, then four frames of scan
    initial begin
        wait (n_cmds > 0);
        #(10 * (RESET_CYCLES + 16 * n_cmds + 4 * frame_cycles()));
        $display("watchdog expired before the test sequence finished");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== bench/cmd_vectors.txt ====
// one command per line: opcode, addr, payload high, payload low
// 50 pixel write (addr = row * 8 + col), 43 config, other opcodes ignored
50000F5A
5007A123
500903C6
4300003F
50120E81
501F077F
50200A5C
502B0FFF
50360396
503D0C3E
4300FFD5
0000007F
50040A96
512400FF
5030060D
50150B4E

// ==== tb.f ====
source/led_matrix_pkg.sv
source/cmd_decode.sv
source/frame_store.sv
source/matrix_scan.sv
source/led_matrix_top.sv
bench/scan_checker.sv
bench/led_matrix_sva.sv
bench/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# build the led matrix testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_top -f tb.f -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -q -F "=== PASS ===" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
